// File: hdl/eeprom_pkg.sv
package eeprom_pkg;

    localparam int QUARTER_CLKS = 4;  // CLK cycles per quarter of SCL
    localparam int QCNT_W = $clog2(QUARTER_CLKS);
    localparam logic [3:0] DEV_TYPE = 4'b1010;
    localparam int EE_ADDR_W = 11;

    // sequencer state bits, one-hot
    localparam int SEQ_STATES = 10;
    localparam int S_IDLE = 0;
    localparam int S_START = 1;
    localparam int S_CTRL_W = 2;
    localparam int S_ADDR = 3;
    localparam int S_DATA = 4;
    localparam int S_RESTART = 5;
    localparam int S_CTRL_R = 6;
    localparam int S_DATA_R = 7;
    localparam int S_STOP = 8;
    localparam int S_RESP = 9;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [EE_ADDR_W-1:0] adr;
        logic [7:0]           dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic       err;
        logic [7:0] dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } byte_op_t;

    typedef struct packed {
        byte_op_t   op;
        logic [7:0] tx;
        logic       nack;  // read only: answer with nack
    } byte_cmd_t;

endpackage

// File: hdl/i2c_byte_engine.sv
`timescale 1ns/100ps
module i2c_byte_engine
    import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  byte_cmd_t  cmd,
    input  logic       cmd_valid,
    output logic       eng_idle,
    output logic       done,
    output logic       rx_nack,
    output logic [7:0] rx_byte,
    output logic       scl_oe,
    output logic       sda_oe,
    input  logic       sda_in
);

    logic              busy;
    byte_op_t          op_q;
    logic              nack_q;
    logic [7:0]        sr;      // tx bits out of the top, rx bits in at the bottom
    logic [QCNT_W-1:0] qcnt;
    logic [1:0]        phase;
    logic [3:0]        bit_cnt;
    logic              q_end;
    logic              bit_end;
    logic              last_bit;
    logic              sample;
    logic              scl_nxt;
    logic              sda_nxt;

    assign q_end    = qcnt == QCNT_W'(QUARTER_CLKS - 1);
    assign bit_end  = q_end && phase == 2'd3;
    assign last_bit = (op_q == OP_START) || (op_q == OP_STOP) || bit_cnt == 4'd8;
    assign sample   = busy && q_end && phase == 2'd1;  // middle of SCL high
    assign done     = busy && bit_end && last_bit;
    assign eng_idle = !busy;
    assign rx_byte  = sr;

    // pull-low requests per quarter
    always_comb
    begin
        scl_nxt = scl_oe;
        sda_nxt = sda_oe;
        case (op_q)
            OP_START:
            begin
                // SCL may still be low here, which gives the repeated start
                scl_nxt = (phase == 2'd0) ? scl_oe : (phase == 2'd3);
                sda_nxt = phase[1];
            end
            OP_STOP:
            begin
                scl_nxt = phase == 2'd0;
                sda_nxt = !phase[1];  // released in the second half of SCL high
            end
            default:
            begin
                scl_nxt = (phase == 2'd0) || (phase == 2'd3);
                if (bit_cnt == 4'd8)
                    sda_nxt = (op_q == OP_READ) && !nack_q;  // ack slot
                else
                    sda_nxt = (op_q == OP_WRITE) && !sr[7];
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            qcnt    <= '0;
            phase   <= 2'd0;
            bit_cnt <= 4'd0;
            scl_oe  <= 1'b0;
            sda_oe  <= 1'b0;
            rx_nack <= 1'b0;
        end
        else if (!busy)
        begin
            if (cmd_valid)
            begin
                busy    <= 1'b1;
                qcnt    <= '0;
                phase   <= 2'd0;
                bit_cnt <= 4'd0;
            end
        end
        else
        begin
            scl_oe <= scl_nxt;
            sda_oe <= sda_nxt;
            qcnt   <= q_end ? '0 : qcnt + 1'b1;
            if (q_end)
                phase <= phase + 2'd1;
            if (bit_end)
                bit_cnt <= bit_cnt + 4'd1;
            if (sample && op_q == OP_WRITE && bit_cnt == 4'd8)
                rx_nack <= sda_in;  // high means no ack from device
            if (done)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!busy && cmd_valid)
        begin
            op_q   <= cmd.op;
            nack_q <= cmd.nack;
            sr     <= cmd.tx;
        end
        else if (busy && op_q == OP_WRITE && bit_end)
            sr <= {sr[6:0], 1'b0};
        else if (sample && op_q == OP_READ && bit_cnt < 4'd8)
            sr <= {sr[6:0], sda_in};
    end

endmodule

// File: hdl/eeprom_sequencer.sv
`timescale 1ns/100ps
module eeprom_sequencer
    import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  wb_req_t    wb_req,
    output wb_rsp_t    wb_rsp,
    output byte_cmd_t  cmd,
    output logic       cmd_valid,
    input  logic       eng_idle,
    input  logic       done,
    input  logic       rx_nack,
    input  logic [7:0] rx_byte
);

    logic [SEQ_STATES-1:0] state;
    logic                  issued;     // command of this state already sent
    logic                  nack_seen;
    logic                  wr_state;
    logic [7:0]            rdat_q;

    function automatic logic [SEQ_STATES-1:0] state_code(input int idx);
        state_code = '0;
        state_code[idx] = 1'b1;
    endfunction

    assign wr_state  = state[S_CTRL_W] || state[S_ADDR] || state[S_DATA] || state[S_CTRL_R];
    assign cmd_valid = |state[S_STOP:S_START] && !issued && eng_idle;

    assign wb_rsp.ack = state[S_RESP] && !nack_seen;
    assign wb_rsp.err = state[S_RESP] && nack_seen;
    assign wb_rsp.dat = rdat_q;

    always_comb
    begin
        cmd.op   = OP_WRITE;
        cmd.tx   = 8'h00;
        cmd.nack = 1'b0;
        unique case (1'b1)
            state[S_START], state[S_RESTART]:
                cmd.op = OP_START;
            state[S_CTRL_W]:
                cmd.tx = {DEV_TYPE, wb_req.adr[EE_ADDR_W-1:8], 1'b0};  // block bits, write
            state[S_ADDR]:
                cmd.tx = wb_req.adr[7:0];
            state[S_DATA]:
                cmd.tx = wb_req.dat;
            state[S_CTRL_R]:
                cmd.tx = {DEV_TYPE, wb_req.adr[EE_ADDR_W-1:8], 1'b1};
            state[S_DATA_R]:
            begin
                cmd.op   = OP_READ;
                cmd.nack = 1'b1;  // single byte, so nack it
            end
            state[S_STOP]:
                cmd.op = OP_STOP;
            default:
            begin
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= state_code(S_IDLE);
            issued    <= 1'b0;
            nack_seen <= 1'b0;
        end
        else
        begin
            if (cmd_valid)
                issued <= 1'b1;
            if (done)
                issued <= 1'b0;
            if (done && wr_state && rx_nack)
                nack_seen <= 1'b1;
            unique case (1'b1)
                state[S_IDLE]:
                    if (wb_req.cyc && wb_req.stb)
                    begin
                        nack_seen <= 1'b0;
                        state     <= state_code(S_START);
                    end
                state[S_START]:
                    if (done)
                        state <= state_code(S_CTRL_W);
                state[S_CTRL_W]:
                    if (done)
                        state <= state_code(rx_nack ? S_STOP : S_ADDR);
                state[S_ADDR]:
                    if (done)
                        state <= state_code(rx_nack ? S_STOP : (wb_req.we ? S_DATA : S_RESTART));
                state[S_DATA]:
                    if (done)
                        state <= state_code(S_STOP);
                state[S_RESTART]:
                    if (done)
                        state <= state_code(S_CTRL_R);
                state[S_CTRL_R]:
                    if (done)
                        state <= state_code(rx_nack ? S_STOP : S_DATA_R);
                state[S_DATA_R]:
                    if (done)
                        state <= state_code(S_STOP);
                state[S_STOP]:
                    if (done)
                        state <= state_code(S_RESP);
                default:
                    state <= state_code(S_IDLE);  // respond lasts one cycle
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (done && state[S_DATA_R])
            rdat_q <= rx_byte;
    end

endmodule

// File: hdl/wb_arbiter.sv
`timescale 1ns/100ps
module wb_arbiter
    import eeprom_pkg::*;
(
    input  logic    CLK,
    input  logic    RESET,
    input  wb_req_t a_req,
    input  wb_req_t b_req,
    output wb_rsp_t a_rsp,
    output wb_rsp_t b_rsp,
    output wb_req_t seq_req,
    input  wb_rsp_t seq_rsp
);

    logic       busy;
    logic [1:0] grant;   // bit 0 port a, bit 1 port b
    logic       last_b;  // b won the last grant
    logic       a_want;
    logic       b_want;

    assign a_want = a_req.cyc && a_req.stb;
    assign b_want = b_req.cyc && b_req.stb;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy   <= 1'b0;
            grant  <= 2'b00;
            last_b <= 1'b1;  // so a goes first
        end
        else if (!busy)
        begin
            if (a_want && (!b_want || last_b))
            begin
                busy   <= 1'b1;
                grant  <= 2'b01;
                last_b <= 1'b0;
            end
            else if (b_want)
            begin
                busy   <= 1'b1;
                grant  <= 2'b10;
                last_b <= 1'b1;
            end
        end
        else if (seq_rsp.ack || seq_rsp.err)
        begin
            busy  <= 1'b0;
            grant <= 2'b00;
        end
    end

    always_comb
    begin
        seq_req     = grant[1] ? b_req : a_req;
        seq_req.cyc = (grant[0] && a_req.cyc) || (grant[1] && b_req.cyc);
        seq_req.stb = (grant[0] && a_req.stb) || (grant[1] && b_req.stb);

        a_rsp     = seq_rsp;
        a_rsp.ack = seq_rsp.ack && grant[0];
        a_rsp.err = seq_rsp.err && grant[0];
        b_rsp     = seq_rsp;
        b_rsp.ack = seq_rsp.ack && grant[1];
        b_rsp.err = seq_rsp.err && grant[1];
    end

endmodule

// File: hdl/eeprom_subsys.sv
`timescale 1ns/100ps
module eeprom_subsys
    import eeprom_pkg::*;
(
    input  logic    CLK,
    input  logic    RESET,
    input  wb_req_t host_a_req,
    input  wb_req_t host_b_req,
    output wb_rsp_t host_a_rsp,
    output wb_rsp_t host_b_rsp,
    output logic    scl_oe,
    output logic    sda_oe,
    input  logic    sda_in
);

    wb_req_t    seq_req;
    wb_rsp_t    seq_rsp;
    byte_cmd_t  cmd;
    logic       cmd_valid;
    logic       eng_idle;
    logic       done;
    logic       rx_nack;
    logic [7:0] rx_byte;

    wb_arbiter u_arbiter (
        .CLK     (CLK),
        .RESET   (RESET),
        .a_req   (host_a_req),
        .b_req   (host_b_req),
        .a_rsp   (host_a_rsp),
        .b_rsp   (host_b_rsp),
        .seq_req (seq_req),
        .seq_rsp (seq_rsp)
    );

    eeprom_sequencer u_sequencer (
        .CLK       (CLK),
        .RESET     (RESET),
        .wb_req    (seq_req),
        .wb_rsp    (seq_rsp),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .eng_idle  (eng_idle),
        .done      (done),
        .rx_nack   (rx_nack),
        .rx_byte   (rx_byte)
    );

    i2c_byte_engine u_engine (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .eng_idle  (eng_idle),
        .done      (done),
        .rx_nack   (rx_nack),
        .rx_byte   (rx_byte),
        .scl_oe    (scl_oe),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

endmodule

// File: verification/eeprom_model.sv
`timescale 1ns/100ps
module eeprom_model
(
    input  logic CLK,
    input  logic scl_oe,
    input  logic sda_oe,
    input  logic ack_en,
    output logic sda_in
);

    logic [7:0] mem [0:2047];
    logic       scl;
    logic       scl_q = 1'b1;
    logic       sda_q = 1'b1;
    logic       pull = 1'b0;    // model pulls SDA low
    logic       active = 1'b0;
    logic       tx_mode = 1'b0;
    logic       rd_pending = 1'b0;
    logic       ack_ok = 1'b0;
    logic [3:0] bit_cnt = 4'd0;
    logic [1:0] byte_idx = 2'd0;
    logic [7:0] sr = 8'h00;
    logic [2:0] blk = 3'd0;
    logic [7:0] addr_lo = 8'h00;
    logic [7:0] rd_byte;
    logic       ack;

    assign scl     = !scl_oe;
    assign sda_in  = !(sda_oe || pull);
    assign rd_byte = mem[{blk, addr_lo}];
    assign ack     = ack_en && (byte_idx != 2'd0 || sr[7:4] == 4'b1010);

    initial
    begin
        logic [10:0] a;
        for (int i = 0; i < 2048; i++)
        begin
            a = 11'(i);
            mem[i] = a[7:0] ^ {a[10:8], a[10:6]};  // uses all address bits
        end
    end

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda_in;
        if (scl_q && scl && sda_q && !sda_in)
        begin
            active   <= 1'b1;  // start or repeated start
            tx_mode  <= 1'b0;
            bit_cnt  <= 4'd0;
            byte_idx <= 2'd0;
            pull     <= 1'b0;
        end
        else if (scl_q && scl && !sda_q && sda_in)
        begin
            active  <= 1'b0;  // stop
            tx_mode <= 1'b0;
            pull    <= 1'b0;
        end
        else if (active && !scl_q && scl)
        begin
            if (bit_cnt < 4'd8)
            begin
                if (!tx_mode)
                    sr <= {sr[6:0], sda_in};
                bit_cnt <= bit_cnt + 4'd1;
            end
            else if (bit_cnt == 4'd8)
                bit_cnt <= 4'd9;
        end
        else if (active && scl_q && !scl)
        begin
            if (tx_mode)
            begin
                if (bit_cnt == 4'd8)
                begin
                    pull   <= 1'b0;  // master answers, single byte only
                    active <= 1'b0;
                end
                else if (bit_cnt != 4'd0)
                begin
                    sr   <= {sr[6:0], 1'b0};
                    pull <= !sr[6];
                end
            end
            else if (bit_cnt == 4'd8)
            begin
                case (byte_idx)
                    2'd0:
                    begin
                        blk        <= sr[3:1];
                        rd_pending <= sr[0];
                    end
                    2'd1:
                        addr_lo <= sr;
                    2'd2:
                        if (ack_en)
                            mem[{blk, addr_lo}] <= sr;  // write cycle ends at once
                    default:
                    begin
                    end
                endcase
                if (byte_idx != 2'd3)
                    byte_idx <= byte_idx + 2'd1;
                ack_ok <= ack;
                pull   <= ack;
            end
            else if (bit_cnt == 4'd9)
            begin
                pull    <= 1'b0;
                bit_cnt <= 4'd0;
                if (!ack_ok)
                    active <= 1'b0;
                else if (rd_pending && byte_idx == 2'd1)
                begin
                    tx_mode <= 1'b1;
                    sr      <= rd_byte;
                    pull    <= !rd_byte[7];
                end
            end
        end
    end

endmodule

// File: verification/eeprom_subsys_chk.sv
`timescale 1ns/100ps
module eeprom_subsys_chk
    import eeprom_pkg::*;
(
    input logic       CLK,
    input logic       RESET,
    input wb_req_t    a_req,
    input wb_req_t    b_req,
    input wb_rsp_t    a_rsp,
    input wb_rsp_t    b_rsp,
    input logic       scl_oe,
    input logic       sda_oe,
    input logic [1:0] grant
);

    a_ack_err_excl: assert property (@(posedge CLK) disable iff (RESET)
        !(a_rsp.ack && a_rsp.err)) else $error("port a ack and err together");
    b_ack_err_excl: assert property (@(posedge CLK) disable iff (RESET)
        !(b_rsp.ack && b_rsp.err)) else $error("port b ack and err together");

    a_rsp_in_cycle: assert property (@(posedge CLK) disable iff (RESET)
        (a_rsp.ack || a_rsp.err) |-> (a_req.cyc && a_req.stb))
        else $error("port a response outside a cycle");
    b_rsp_in_cycle: assert property (@(posedge CLK) disable iff (RESET)
        (b_rsp.ack || b_rsp.err) |-> (b_req.cyc && b_req.stb))
        else $error("port b response outside a cycle");

    grant_onehot: assert property (@(posedge CLK) disable iff (RESET)
        grant != 2'b11) else $error("grant on both ports");

    // bus released right out of reset
    bus_idle_after_reset: assert property (@(posedge CLK)
        RESET |=> (!scl_oe && !sda_oe)) else $error("bus driven after reset");

endmodule

bind eeprom_subsys eeprom_subsys_chk u_chk (
    .CLK    (CLK),
    .RESET  (RESET),
    .a_req  (host_a_req),
    .b_req  (host_b_req),
    .a_rsp  (host_a_rsp),
    .b_rsp  (host_b_rsp),
    .scl_oe (scl_oe),
    .sda_oe (sda_oe),
    .grant  (u_arbiter.grant)
);

// File: verification/tb_eeprom_subsys.sv
`timescale 1ns/100ps
module tb_eeprom_subsys
    import eeprom_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 20000;

    logic        CLK;
    logic        RESET;
    wb_req_t     a_req;
    wb_req_t     b_req;
    wb_rsp_t     a_rsp;
    wb_rsp_t     b_rsp;
    logic        scl_oe;
    logic        sda_oe;
    logic        sda_in;
    logic        ack_en;
    logic [31:0] lfsr_state = 32'hab31_cd36;
    logic [7:0]  exp_mem [0:2047];
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          done_count = 0;

    eeprom_subsys u_dut (
        .CLK        (CLK),
        .RESET      (RESET),
        .host_a_req (a_req),
        .host_b_req (b_req),
        .host_a_rsp (a_rsp),
        .host_b_rsp (b_rsp),
        .scl_oe     (scl_oe),
        .sda_oe     (sda_oe),
        .sda_in     (sda_in)
    );

    eeprom_model u_model (
        .CLK    (CLK),
        .scl_oe (scl_oe),
        .sda_oe (sda_oe),
        .ack_en (ack_en),
        .sda_in (sda_in)
    );

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERROR %0t: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_result(input string name, input int errs_before);
        if (errors == errs_before)
        begin
            tests_passed++;
            $display("test %s: pass", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: fail", name);
        end
    endtask

    // one Wishbone classic cycle on port 0 (a) or 1 (b)
    task automatic wb_xfer(input int port, input logic we, input logic [10:0] adr,
                           input logic [7:0] wdat, output logic [7:0] rdat,
                           output logic got_ack, output logic got_err);
        wb_req_t req;
        wb_rsp_t rsp;
        int      n;
        req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        got_ack = 1'b0;
        got_err = 1'b0;
        rdat = 8'h00;
        @(negedge CLK);
        if (port == 0)
            a_req = req;
        else
            b_req = req;
        for (n = 0; n < TIMEOUT_CYCLES; n++)
        begin
            @(negedge CLK);
            rsp = (port == 0) ? a_rsp : b_rsp;
            if (rsp.ack || rsp.err)
                break;
        end
        if (n == TIMEOUT_CYCLES)
        begin
            $display("port %s stalled: no ack or err after %0d cycles",
                     (port == 0) ? "a" : "b", TIMEOUT_CYCLES);
            errors++;
        end
        else
        begin
            got_ack = rsp.ack;
            got_err = rsp.err;
            rdat = rsp.dat;
            @(negedge CLK);  // request held through the ack cycle
        end
        if (port == 0)
            a_req = '0;
        else
            b_req = '0;
    endtask

    task automatic write_ok(input int port, input logic [10:0] adr, input logic [7:0] d);
        logic [7:0] r;
        logic       k;
        logic       e;
        wb_xfer(port, 1'b1, adr, d, r, k, e);
        check("write ack", 32'(k), 32'd1);
        check("write err", 32'(e), 32'd0);
        exp_mem[adr] = d;
    endtask

    task automatic read_check(input int port, input logic [10:0] adr);
        logic [7:0] r;
        logic       k;
        logic       e;
        wb_xfer(port, 1'b0, adr, 8'h00, r, k, e);
        check("read ack", 32'(k), 32'd1);
        check("read data", 32'(r), 32'(exp_mem[adr]));
    endtask

    task automatic idle_after_reset();
        int e0;
        e0 = errors;
        repeat (50) @(negedge CLK);
        check("scl_oe", 32'(scl_oe), 32'd0);
        check("sda_oe", 32'(sda_oe), 32'd0);
        check("port a ack/err", 32'({a_rsp.ack, a_rsp.err}), 32'd0);
        check("port b ack/err", 32'({b_rsp.ack, b_rsp.err}), 32'd0);
        report_result("reset state", e0);
    endtask

    task automatic write_then_read();
        int e0;
        e0 = errors;
        write_ok(0, 11'h5a3, 8'hc6);
        read_check(0, 11'h5a3);
        check("model memory", 32'(u_model.mem[11'h5a3]), 32'h0000_00c6);
        report_result("write then read", e0);
    endtask

    task automatic random_traffic();
        int          e0;
        logic [31:0] v;
        logic [10:0] addrs [20];
        e0 = errors;
        for (int i = 0; i < 20; i++)
        begin
            take_bits(11, v);
            addrs[i] = v[10:0];
            take_bits(8, v);
            write_ok(i % 2, addrs[i], v[7:0]);
        end
        for (int i = 0; i < 20; i++)
        begin
            read_check(i % 2, addrs[i]);
            check("model memory", 32'(u_model.mem[addrs[i]]), 32'(exp_mem[addrs[i]]));
        end
        report_result("random traffic", e0);
    endtask

    task automatic port_contention();
        int         e0;
        int         a_rank;
        int         b_rank;
        logic [7:0] ra;
        logic [7:0] rb;
        logic       ka;
        logic       kb;
        logic       ea;
        logic       eb;
        e0 = errors;
        done_count = 0;
        fork
            begin
                wb_xfer(0, 1'b1, 11'h0f1, 8'h3c, ra, ka, ea);
                done_count++;
                a_rank = done_count;
            end
            begin
                wb_xfer(1, 1'b1, 11'h70e, 8'ha5, rb, kb, eb);
                done_count++;
                b_rank = done_count;
            end
        join
        exp_mem[11'h0f1] = 8'h3c;
        exp_mem[11'h70e] = 8'ha5;
        check("port a ack", 32'(ka), 32'd1);
        check("port b ack", 32'(kb), 32'd1);
        check("port a finished first", 32'(a_rank), 32'd1);
        check("port b finished second", 32'(b_rank), 32'd2);
        read_check(1, 11'h0f1);
        read_check(0, 11'h70e);
        report_result("contention", e0);
    endtask

    task automatic device_nack_recovery();
        int         e0;
        logic [7:0] r;
        logic       k;
        logic       e;
        e0 = errors;
        @(negedge CLK) ack_en = 1'b0;
        wb_xfer(0, 1'b0, 11'h2b4, 8'h00, r, k, e);
        check("nack read ack", 32'(k), 32'd0);
        check("nack read err", 32'(e), 32'd1);
        @(negedge CLK) ack_en = 1'b1;
        write_ok(1, 11'h2b4, 8'h81);
        read_check(0, 11'h2b4);
        report_result("device nack", e0);
    endtask

    initial
    begin
        RESET = 1'b1;
        a_req = '0;
        b_req = '0;
        ack_en = 1'b1;
        repeat (3) @(posedge CLK);
        @(negedge CLK) RESET = 1'b0;
        idle_after_reset();
        write_then_read();
        random_traffic();
        port_contention();
        device_nack_recovery();
        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: build.f
hdl/eeprom_pkg.sv
hdl/i2c_byte_engine.sv
hdl/eeprom_sequencer.sv
hdl/wb_arbiter.sv
hdl/eeprom_subsys.sv
verification/eeprom_model.sv
verification/eeprom_subsys_chk.sv
verification/tb_eeprom_subsys.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_eeprom_subsys \
    -f build.f -Mdir obj_dir -o sim_eeprom > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    cat build.log
    exit 1
fi

./obj_dir/sim_eeprom > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
